// File: all.f
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_control.sv
source/rv_core.sv
tests/tb_clock.sv
tests/tb_memory.sv
tests/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - source/rv_pkg.sv
  - source/rv_decoder.sv
  - source/rv_regfile.sv
  - source/rv_alu.sv
  - source/rv_control.sv
  - source/rv_core.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_memory.sv
      - tests/rv_core_tb.sv

// File: tests/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam int programs = 4;
  localparam int unsigned cycle_limit = programs * 4000;
  localparam logic [31:0] store_base = 32'h700;
  localparam logic [31:0] data_addr = 32'h7f0;
  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_imm = 7'b0010011;
  localparam logic [6:0] opc_load = 7'b0000011;
  localparam logic [6:0] opc_jalr = 7'b1100111;

  logic clk;
  logic reset;
  logic restart;
  logic [1:0] delay;
  logic trap;
  rv_pkg::mem_req_t mem_req;
  rv_pkg::mem_rsp_t mem_rsp;

  logic [31:0] data_lfsr = 32'h13a2;
  logic [31:0] delay_lfsr = 32'h13a2;
  logic [31:0] pc_emit;
  logic [31:0] last_fetch;
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int unsigned cycles = 0;
  int unsigned errors = 0;
  int unsigned stores_checked = 0;
  int unsigned data_reqs = 0;
  logic reset_q;
  logic first_fetch;
  logic hold_pending;
  rv_pkg::mem_req_t prev_req;

  tb_clock clock_i (.restart(restart), .clk(clk), .reset(reset));

  tb_memory memory_i (.clk(clk), .mem_req(mem_req), .mem_rsp(mem_rsp), .delay(delay));

  rv_core rv_core_i (
    .clk(clk),
    .reset(reset),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp),
    .trap(trap)
  );

  // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], data_lfsr[0]};
      data_lfsr = lfsr_step(data_lfsr);
    end
    return v;
  endfunction

  function automatic logic [31:0] imm_instr(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opcode);
    return {imm, rs1, f3, rd, opcode};
  endfunction

  function automatic logic [31:0] reg_instr(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] sw_instr(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch_instr(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] upper_instr(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opcode);
    return {imm, rd, opcode};
  endfunction

  function automatic logic [31:0] jal_instr(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // rv32i reference results
  function automatic logic [31:0] alu_expect(input logic [2:0] f3, input logic alt,
      input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) begin
          return sa >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_expect(input logic [2:0] f3, input logic [31:0] a,
      input logic [31:0] b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  task automatic emit(input logic [31:0] word);
    memory_i.put(pc_emit, word);
    pc_emit = pc_emit + 32'd4;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit(upper_instr(upper[31:12], rd, opc_lui));
    emit(imm_instr(value[11:0], rd, 3'b000, rd, opc_imm));
  endtask

  task automatic build_alu_tests();
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    logic [2:0] f3;
    logic alt;
    // x10 holds the store address for the whole program
    emit(imm_instr(store_base[11:0], 5'd0, 3'b000, 5'd10, opc_imm));
    for (int k = 0; k < 10; k++) begin
      f3 = k < 8 ? 3'(k) : (k == 8 ? 3'b000 : 3'b101);
      alt = k >= 8;
      a = take_bits(32);
      b = take_bits(32);
      load_const(5'd1, a);
      load_const(5'd2, b);
      emit(reg_instr(alt ? 7'b0100000 : 7'b0, 5'd2, 5'd1, f3, 5'd3));
      emit(sw_instr(12'd0, 5'd3, 5'd10));
      expect_store(store_base, alu_expect(f3, alt, a, b));
    end
    for (int k = 0; k < 9; k++) begin
      f3 = k < 8 ? 3'(k) : 3'b101;
      alt = k == 8;
      a = take_bits(32);
      imm = 12'(take_bits(12));
      if (f3 == 3'b001 || f3 == 3'b101) begin
        imm = {1'b0, alt, 5'b0, imm[4:0]};
      end
      load_const(5'd1, a);
      emit(imm_instr(imm, 5'd1, f3, 5'd3, opc_imm));
      emit(sw_instr(12'd0, 5'd3, 5'd10));
      expect_store(store_base, alu_expect(f3, alt, a, {{20{imm[11]}}, imm}));
    end
  endtask

  task automatic build_load_auipc_tests();
    logic [31:0] word;
    logic [19:0] upper;
    word = take_bits(32);
    memory_i.put(data_addr, word);
    emit(imm_instr(data_addr[11:0], 5'd0, 3'b000, 5'd11, opc_imm));
    emit(imm_instr(12'd0, 5'd11, 3'b010, 5'd4, opc_load));
    emit(sw_instr(12'd4, 5'd4, 5'd10));
    expect_store(store_base + 32'd4, word);
    for (int k = 0; k < 3; k++) begin
      upper = 20'(take_bits(20));
      expect_store(store_base, pc_emit + {upper, 12'b0});
      emit(upper_instr(upper, 5'd3, opc_auipc));
      emit(sw_instr(12'd0, 5'd3, 5'd10));
    end
  endtask

  task automatic build_flow_tests();
    int lhs [3] = '{5, -3, 7};
    int rhs [3] = '{5, 7, -3};
    logic [2:0] f3;
    logic [31:0] base;
    int marker;
    for (int f = 0; f < 6; f++) begin
      f3 = f < 2 ? 3'(f) : 3'(f + 2);
      for (int p = 0; p < 3; p++) begin
        marker = 32 + (f * 3 + p) * 2;
        emit(imm_instr(12'(lhs[p]), 5'd0, 3'b000, 5'd1, opc_imm));
        emit(imm_instr(12'(rhs[p]), 5'd0, 3'b000, 5'd2, opc_imm));
        emit(branch_instr(13'd16, 5'd2, 5'd1, f3));
        // fall-through path then a jump over the taken path
        emit(imm_instr(12'(marker), 5'd0, 3'b000, 5'd5, opc_imm));
        emit(sw_instr(12'd0, 5'd5, 5'd10));
        emit(jal_instr(21'd12, 5'd0));
        emit(imm_instr(12'(marker + 1), 5'd0, 3'b000, 5'd5, opc_imm));
        emit(sw_instr(12'd0, 5'd5, 5'd10));
        expect_store(store_base, branch_expect(f3, lhs[p], rhs[p]) ? 32'(marker + 1) : 32'(marker));
      end
    end
    expect_store(store_base, pc_emit + 32'd4);
    emit(jal_instr(21'd12, 5'd6));
    emit(imm_instr(12'h7ff, 5'd0, 3'b000, 5'd5, opc_imm));
    emit(sw_instr(12'd0, 5'd5, 5'd10));
    emit(sw_instr(12'd0, 5'd6, 5'd10));
    // odd offset so bit 0 of the target gets cleared
    base = pc_emit;
    emit(upper_instr(20'h0, 5'd7, opc_auipc));
    emit(imm_instr(12'd21, 5'd7, 3'b000, 5'd6, opc_jalr));
    emit(imm_instr(12'h7ff, 5'd0, 3'b000, 5'd5, opc_imm));
    emit(sw_instr(12'd0, 5'd5, 5'd10));
    emit(sw_instr(12'd0, 5'd5, 5'd10));
    emit(sw_instr(12'd0, 5'd6, 5'd10));
    expect_store(store_base, base + 32'd8);
  endtask

  task automatic run_program(input int kind);
    int unsigned reqs_before;
    int unsigned data_want;
    if (kind != 0) begin
      @(posedge clk);
      restart <= 1'b1;
      @(posedge clk);
      restart <= 1'b0;
      @(posedge clk);
    end
    memory_i.fill();
    exp_addr.delete();
    exp_data.delete();
    pc_emit = 32'h0;
    case (kind)
      0: begin
        build_alu_tests();
        build_load_auipc_tests();
        build_flow_tests();
        emit(32'h0000_0073);
      end
      // lb is outside the kept subset
      1: emit(imm_instr(12'd0, 5'd0, 3'b000, 5'd4, opc_load));
      2: begin
        emit(imm_instr(12'h102, 5'd0, 3'b000, 5'd11, opc_imm));
        emit(imm_instr(12'd0, 5'd11, 3'b010, 5'd4, opc_load));
      end
      default: begin
        emit(imm_instr(12'h102, 5'd0, 3'b000, 5'd7, opc_imm));
        emit(imm_instr(12'd0, 5'd7, 3'b000, 5'd1, opc_jalr));
      end
    endcase
    // every planned store plus the single lw of the first program
    data_want = exp_addr.size() + (kind == 0 ? 1 : 0);
    last_fetch = '1;
    reqs_before = data_reqs;
    while (reset) begin
      @(posedge clk);
    end
    while (!trap) begin
      @(posedge clk);
    end
    // watch the bus stay idle after the trap
    repeat (16) @(posedge clk);
    assert (trap) else report_mismatch($sformatf("program %0d: trap dropped", kind));
    assert (exp_addr.size() == 0)
      else report_mismatch($sformatf("program %0d: %0d stores missing", kind, exp_addr.size()));
    // the trapping instruction is always the last one placed
    assert (last_fetch == pc_emit - 32'd4)
      else report_mismatch($sformatf("program %0d: last fetch at %h, trap expected at %h",
                                     kind, last_fetch, pc_emit - 32'd4));
    assert (data_reqs - reqs_before == data_want)
      else report_mismatch($sformatf("program %0d: %0d data transfers, expected %0d",
                                     kind, data_reqs - reqs_before, data_want));
  endtask

  always @(posedge clk) begin
    logic [31:0] s;
    s = lfsr_step(delay_lfsr);
    delay <= {delay_lfsr[0], s[0]};
    delay_lfsr <= lfsr_step(s);
  end

  always @(posedge clk) begin
    logic [31:0] want_addr;
    logic [31:0] want_data;
    if (!reset && mem_req.valid && mem_rsp.ready) begin
      if (mem_req.instr) begin
        last_fetch = mem_req.addr;
      end else begin
        data_reqs++;
      end
    end
    if (!reset && mem_req.valid && mem_rsp.ready && mem_req.wstrb != 4'h0) begin
      stores_checked++;
      if (exp_addr.size() == 0) begin
        report_mismatch($sformatf("unexpected store %h to %h", mem_req.wdata, mem_req.addr));
      end else begin
        want_addr = exp_addr.pop_front();
        want_data = exp_data.pop_front();
        assert (mem_req.addr == want_addr && mem_req.wdata == want_data &&
                mem_req.wstrb == 4'hf && !mem_req.instr)
          else report_mismatch($sformatf("store %h to %h, expected %h to %h",
                                         mem_req.wdata, mem_req.addr, want_data, want_addr));
      end
    end
  end

  always @(posedge clk) begin
    if (reset_q) begin
      assert (!mem_req.valid && !trap) else report_mismatch("valid or trap high after reset");
    end
    if (!reset) begin
      if (first_fetch && mem_req.valid) begin
        assert (mem_req.instr && mem_req.addr == 32'h0 && mem_req.wstrb == 4'h0)
          else report_mismatch($sformatf("first request at %h is not a fetch of 0", mem_req.addr));
      end
      if (hold_pending) begin
        assert (mem_req == prev_req) else report_mismatch("request changed before ready");
      end
      if (mem_req.valid) begin
        assert (mem_req.addr[1:0] == 2'b00)
          else report_mismatch($sformatf("misaligned request to %h", mem_req.addr));
      end
      if (trap) begin
        assert (!mem_req.valid) else report_mismatch("request issued while trapped");
      end
    end
    reset_q <= reset;
    first_fetch <= reset || (first_fetch && !mem_req.valid);
    hold_pending <= !reset && mem_req.valid && !mem_rsp.ready;
    prev_req <= mem_req;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("stores checked %0d, errors %0d", stores_checked, errors);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    restart = 1'b0;
    delay = 2'd0;
    reset_q = 1'b0;
    first_fetch = 1'b1;
    hold_pending = 1'b0;
    prev_req = '0;
    for (int kind = 0; kind < programs; kind++) begin
      run_program(kind);
    end
    $display("stores checked %0d, errors %0d", stores_checked, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: tests/tb_memory.sv
`timescale 1ns/1ps

module tb_memory (
  input  logic             clk,
  input  rv_pkg::mem_req_t mem_req,
  output rv_pkg::mem_rsp_t mem_rsp,
  input  logic [1:0]       delay
);

  localparam int words = 1024;

  logic [31:0] mem [words];
  logic busy;
  logic [1:0] wait_left;

  initial begin
    mem_rsp = '0;
    busy = 1'b0;
    wait_left = 2'd0;
  end

  // every word gets a value made from its own byte address
  task automatic fill();
    logic [31:0] addr;
    for (int i = 0; i < words; i++) begin
      addr = 32'(i) << 2;
      mem[i] = {~addr[15:0], addr[15:0]};
    end
  endtask

  task automatic put(input logic [31:0] addr, input logic [31:0] data);
    mem[addr[11:2]] = data;
  endtask

  always @(posedge clk) begin
    if (mem_rsp.ready) begin
      mem_rsp.ready <= 1'b0;
      busy <= 1'b0;
    end else if (!mem_req.valid) begin
      busy <= 1'b0;
    end else if (!busy) begin
      busy <= 1'b1;
      wait_left <= delay;
    end else if (wait_left != 2'd0) begin
      wait_left <= wait_left - 2'd1;
    end else begin
      mem_rsp.ready <= 1'b1;
      mem_rsp.rdata <= mem[mem_req.addr[11:2]];
      if (mem_req.wstrb == 4'hf) begin
        mem[mem_req.addr[11:2]] <= mem_req.wdata;
      end
    end
  end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  input  logic restart,
  output logic clk,
  output logic reset
);

  int unsigned held;

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    held = 0;
  end

  always #4 clk = ~clk;

  // reset stays high for 8 rising edges, again after each restart
  always @(posedge clk) begin
    if (restart) begin
      reset <= 1'b1;
      held <= 0;
    end else if (reset) begin
      if (held == 7) begin
        reset <= 1'b0;
      end
      held <= held + 1;
    end
  end

endmodule

// File: source/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic             clk,
  input  logic             reset,
  output rv_pkg::mem_req_t mem_req,
  input  rv_pkg::mem_rsp_t mem_rsp,
  output logic             trap
);

  rv_pkg::instr_t instr;
  rv_pkg::decode_t dec;
  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_result;
  rv_pkg::word_t rf_wdata;
  logic taken;
  logic rf_we;

  // immediate forms take shift amount from the immediate too
  assign alu_b = dec.use_imm ? dec.imm : rs2_data;

  rv_control control_i (
    .clk(clk),
    .reset(reset),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp),
    .instr(instr),
    .dec(dec),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .alu_result(alu_result),
    .taken(taken),
    .rf_we(rf_we),
    .rf_wdata(rf_wdata),
    .trap(trap)
  );

  rv_decoder decoder_i (
    .instr(instr),
    .dec(dec)
  );

  rv_regfile regfile_i (
    .clk(clk),
    .reset(reset),
    .rs1(dec.rs1),
    .rs2(dec.rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .we(rf_we),
    .rd(dec.rd),
    .wdata(rf_wdata)
  );

  rv_alu alu_i (
    .op(dec.alu_op),
    .a(rs1_data),
    .b(alu_b),
    .shamt(alu_b[4:0]),
    .result(alu_result),
    .taken(taken)
  );

endmodule

// File: source/rv_control.sv
`timescale 1ns/1ps

module rv_control (
  input  logic             clk,
  input  logic             reset,
  output rv_pkg::mem_req_t mem_req,
  input  rv_pkg::mem_rsp_t mem_rsp,
  output rv_pkg::instr_t   instr,
  input  rv_pkg::decode_t  dec,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  input  rv_pkg::word_t    alu_result,
  input  logic             taken,
  output logic             rf_we,
  output rv_pkg::word_t    rf_wdata,
  output logic             trap
);

  typedef enum logic [2:0] {
    st_fetch,
    st_wait_fetch,
    st_execute,
    st_load_wait,
    st_store_wait,
    st_reg_write,
    st_pc_check,
    st_trap
  } state_t;

  state_t state;
  rv_pkg::word_t pc;
  rv_pkg::word_t next_pc;
  rv_pkg::word_t wb_data;
  rv_pkg::word_t ls_addr;
  rv_pkg::word_t seq_pc;

  assign ls_addr = rs1_data + dec.imm;
  assign seq_pc = pc + rv_pkg::instr_bytes;

  assign rf_we = state == st_reg_write;
  assign rf_wdata = wb_data;
  // trap state is only left through reset
  assign trap = state == st_trap;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      next_pc <= rv_pkg::reset_pc;
      mem_req <= '0;
    end else begin
      case (state)
        st_fetch: begin
          mem_req.valid <= 1'b1;
          mem_req.instr <= 1'b1;
          mem_req.addr <= next_pc;
          mem_req.wstrb <= '0;
          state <= st_wait_fetch;
        end

        st_wait_fetch: begin
          if (mem_rsp.ready) begin
            mem_req.valid <= 1'b0;
            pc <= mem_req.addr;
            instr.raw <= mem_rsp.rdata;
            state <= st_execute;
          end
        end

        st_execute: begin
          case (dec.op_class)
            rv_pkg::class_lui: begin
              wb_data <= dec.imm;
              next_pc <= seq_pc;
              state <= st_reg_write;
            end
            rv_pkg::class_auipc: begin
              wb_data <= pc + dec.imm;
              next_pc <= seq_pc;
              state <= st_reg_write;
            end
            rv_pkg::class_alu: begin
              wb_data <= alu_result;
              next_pc <= seq_pc;
              state <= st_reg_write;
            end
            rv_pkg::class_jal: begin
              wb_data <= seq_pc;
              next_pc <= pc + dec.imm;
              state <= st_reg_write;
            end
            rv_pkg::class_jalr: begin
              wb_data <= seq_pc;
              next_pc <= {ls_addr[rv_pkg::xlen-1:1], 1'b0};
              state <= st_reg_write;
            end
            rv_pkg::class_branch: begin
              next_pc <= taken ? pc + dec.imm : seq_pc;
              state <= st_pc_check;
            end
            rv_pkg::class_load: begin
              if (ls_addr[1:0] != 2'b00) begin
                state <= st_trap;
              end else begin
                mem_req.valid <= 1'b1;
                mem_req.instr <= 1'b0;
                mem_req.addr <= ls_addr;
                mem_req.wstrb <= '0;
                state <= st_load_wait;
              end
            end
            rv_pkg::class_store: begin
              if (ls_addr[1:0] != 2'b00) begin
                state <= st_trap;
              end else begin
                mem_req.valid <= 1'b1;
                mem_req.instr <= 1'b0;
                mem_req.addr <= ls_addr;
                mem_req.wdata <= rs2_data;
                mem_req.wstrb <= '1;
                state <= st_store_wait;
              end
            end
            default: state <= st_trap;
          endcase
        end

        st_load_wait: begin
          if (mem_rsp.ready) begin
            mem_req.valid <= 1'b0;
            wb_data <= mem_rsp.rdata;
            next_pc <= seq_pc;
            state <= st_reg_write;
          end
        end

        st_store_wait: begin
          if (mem_rsp.ready) begin
            mem_req.valid <= 1'b0;
            next_pc <= seq_pc;
            state <= st_fetch;
          end
        end

        // jumps still need their target checked
        st_reg_write: begin
          if (dec.op_class == rv_pkg::class_jal || dec.op_class == rv_pkg::class_jalr) begin
            state <= st_pc_check;
          end else begin
            state <= st_fetch;
          end
        end

        st_pc_check: begin
          if (next_pc[1:0] != 2'b00) begin
            state <= st_trap;
          end else begin
            state <= st_fetch;
          end
        end

        default: state <= st_trap;
      endcase
    end
  end

endmodule

// File: source/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  logic [4:0]      shamt,
  output rv_pkg::word_t   result,
  output logic            taken
);

  logic lt_signed;
  logic lt_unsigned;

  assign lt_signed = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    result = '0;
    taken = 1'b0;
    case (op)
      rv_pkg::alu_add: result = a + b;
      rv_pkg::alu_sub: result = a - b;
      rv_pkg::alu_sll: result = a << shamt;
      rv_pkg::alu_slt: result = {31'b0, lt_signed};
      rv_pkg::alu_sltu: result = {31'b0, lt_unsigned};
      rv_pkg::alu_xor: result = a ^ b;
      rv_pkg::alu_srl: result = a >> shamt;
      rv_pkg::alu_sra: result = $signed(a) >>> shamt;
      rv_pkg::alu_or: result = a | b;
      rv_pkg::alu_and: result = a & b;
      // branch compares only drive taken
      rv_pkg::alu_beq: taken = a == b;
      rv_pkg::alu_bne: taken = a != b;
      rv_pkg::alu_blt: taken = lt_signed;
      rv_pkg::alu_bge: taken = !lt_signed;
      rv_pkg::alu_bltu: taken = lt_unsigned;
      rv_pkg::alu_bgeu: taken = !lt_unsigned;
      default: result = '0;
    endcase
  end

endmodule

// File: source/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    wdata
);

  rv_pkg::word_t regs [rv_pkg::reg_count];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < rv_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 always reads as zero
  assign rs1_data = rs1 == '0 ? '0 : regs[rs1];
  assign rs2_data = rs2 == '0 ? '0 : regs[rs2];

endmodule

// File: source/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::instr_t  instr,
  output rv_pkg::decode_t dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic alu_reg;
  logic plain_f7;
  logic alu_legal;
  rv_pkg::alu_op_t alu_fn;
  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_u;
  rv_pkg::word_t imm_j;

  assign opcode = instr.r.opcode;
  assign funct3 = instr.r.funct3;
  assign funct7 = instr.r.funct7;

  // immediates straight from the format views
  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                  instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
  assign imm_u = {instr.u.imm, 12'b0};
  assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                  instr.j.imm_11, instr.j.imm_10_1, 1'b0};

  assign alu_reg = opcode == rv_pkg::op_alu_reg;
  // immediate forms carry immediate bits where funct7 would be
  assign plain_f7 = !alu_reg || funct7 == rv_pkg::f7_base;

  // alu function shared by register and immediate forms
  always_comb begin
    alu_fn = rv_pkg::alu_add;
    alu_legal = plain_f7;
    case (funct3)
      rv_pkg::f3_add: begin
        if (alu_reg && funct7 == rv_pkg::f7_alt) begin
          alu_fn = rv_pkg::alu_sub;
          alu_legal = 1'b1;
        end
      end
      rv_pkg::f3_sll: begin
        alu_fn = rv_pkg::alu_sll;
        alu_legal = funct7 == rv_pkg::f7_base;
      end
      rv_pkg::f3_slt: alu_fn = rv_pkg::alu_slt;
      rv_pkg::f3_sltu: alu_fn = rv_pkg::alu_sltu;
      rv_pkg::f3_xor: alu_fn = rv_pkg::alu_xor;
      rv_pkg::f3_srl: begin
        alu_fn = funct7 == rv_pkg::f7_alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
        alu_legal = funct7 == rv_pkg::f7_base || funct7 == rv_pkg::f7_alt;
      end
      rv_pkg::f3_or: alu_fn = rv_pkg::alu_or;
      rv_pkg::f3_and: alu_fn = rv_pkg::alu_and;
      default: alu_legal = 1'b0;
    endcase
  end

  always_comb begin
    dec.op_class = rv_pkg::class_illegal;
    dec.alu_op = rv_pkg::alu_add;
    dec.rd = instr.r.rd;
    dec.rs1 = instr.r.rs1;
    dec.rs2 = instr.r.rs2;
    dec.imm = '0;
    dec.use_imm = 1'b0;
    case (opcode)
      rv_pkg::op_lui: begin
        dec.op_class = rv_pkg::class_lui;
        dec.imm = imm_u;
      end
      rv_pkg::op_auipc: begin
        dec.op_class = rv_pkg::class_auipc;
        dec.imm = imm_u;
      end
      rv_pkg::op_jal: begin
        dec.op_class = rv_pkg::class_jal;
        dec.imm = imm_j;
      end
      rv_pkg::op_jalr: begin
        if (funct3 == rv_pkg::f3_jalr) begin
          dec.op_class = rv_pkg::class_jalr;
        end
        dec.imm = imm_i;
      end
      rv_pkg::op_branch: begin
        dec.op_class = rv_pkg::class_branch;
        dec.imm = imm_b;
        dec.rd = '0;
        case (funct3)
          rv_pkg::f3_beq: dec.alu_op = rv_pkg::alu_beq;
          rv_pkg::f3_bne: dec.alu_op = rv_pkg::alu_bne;
          rv_pkg::f3_blt: dec.alu_op = rv_pkg::alu_blt;
          rv_pkg::f3_bge: dec.alu_op = rv_pkg::alu_bge;
          rv_pkg::f3_bltu: dec.alu_op = rv_pkg::alu_bltu;
          rv_pkg::f3_bgeu: dec.alu_op = rv_pkg::alu_bgeu;
          default: dec.op_class = rv_pkg::class_illegal;
        endcase
      end
      // only full words, byte and halfword forms stay illegal
      rv_pkg::op_load: begin
        if (funct3 == rv_pkg::f3_word) begin
          dec.op_class = rv_pkg::class_load;
        end
        dec.imm = imm_i;
      end
      rv_pkg::op_store: begin
        if (funct3 == rv_pkg::f3_word) begin
          dec.op_class = rv_pkg::class_store;
        end
        dec.imm = imm_s;
        dec.rd = '0;
      end
      rv_pkg::op_alu_imm, rv_pkg::op_alu_reg: begin
        if (alu_legal) begin
          dec.op_class = rv_pkg::class_alu;
        end
        dec.alu_op = alu_fn;
        dec.imm = imm_i;
        dec.use_imm = !alu_reg;
      end
      // ecall and ebreak both trap
      rv_pkg::op_system: dec.op_class = rv_pkg::class_illegal;
      default: dec.op_class = rv_pkg::class_illegal;
    endcase
  end

endmodule

// File: source/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_count = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

  localparam word_t reset_pc = '0;
  localparam word_t instr_bytes = 32'd4;

  // major opcodes
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_jalr = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_alu_imm = 7'b0010011;
  localparam logic [6:0] op_alu_reg = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 codes
  localparam logic [2:0] f3_word = 3'b010;
  localparam logic [2:0] f3_jalr = 3'b000;
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_blt = 3'b100;
  localparam logic [2:0] f3_bge = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_srl = 3'b101;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct7 selects sub and sra
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word seen through every format
  typedef union packed {
    word_t  raw;
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_t;

  typedef enum logic [3:0] {
    class_lui,
    class_auipc,
    class_jal,
    class_jalr,
    class_branch,
    class_load,
    class_store,
    class_alu,
    class_illegal
  } op_class_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_beq,
    alu_bne,
    alu_blt,
    alu_bge,
    alu_bltu,
    alu_bgeu
  } alu_op_t;

  typedef struct packed {
    op_class_t op_class;
    alu_op_t   alu_op;
    reg_idx_t  rd;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    word_t     imm;
    logic      use_imm;
  } decode_t;

  typedef struct packed {
    logic       valid;
    logic       instr;
    word_t      addr;
    word_t      wdata;
    logic [3:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic  ready;
    word_t rdata;
  } mem_rsp_t;

endpackage
